/* hw/axi_macros.svh */
// bus widths and address map constants for the axi memory subsystem
`ifndef AXI_MACROS_SVH
`define AXI_MACROS_SVH

// bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)
`define AXI_ID_WIDTH 4

// clint region, 64 KB
`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'hFFFF_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS 32'h0000_BFF8

// sram region, 4 KB of 8-byte words
`define SRAM_BASE 32'h8000_0000
`define SRAM_MASK 32'hFFFF_F000
`define SRAM_WORDS 512

`endif

/* hw/axi_pkg.sv */
// axi channel payloads and the request/response bundles passed between blocks
`include "axi_macros.svh"

package axi_pkg;

	// shared by aw and ar
	typedef struct packed {
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [7:0]                 len;
		logic [2:0]                 size;
		logic [1:0]                 burst;
	} axi_ax_t;

	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic [`AXI_STRB_WIDTH-1:0] strb;
		logic                       last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0]               resp;
		logic [`AXI_ID_WIDTH-1:0] id;
	} axi_b_t;

	typedef struct packed {
		logic [1:0]                 resp;
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic                       last;
		logic [`AXI_ID_WIDTH-1:0]   id;
	} axi_r_t;

	// master to slave
	typedef struct packed {
		logic    aw_valid;
		axi_ax_t aw;
		logic    w_valid;
		axi_w_t  w;
		logic    b_ready;
		logic    ar_valid;
		axi_ax_t ar;
		logic    r_ready;
	} axi_req_t;

	// slave to master
	typedef struct packed {
		logic   aw_ready;
		logic   w_ready;
		logic   b_valid;
		axi_b_t b;
		logic   ar_ready;
		logic   r_valid;
		axi_r_t r;
	} axi_resp_t;

	// byte-lane merge of write data into an existing word
	function automatic logic [`AXI_DATA_WIDTH-1:0] strb_merge(
		input logic [`AXI_DATA_WIDTH-1:0] old_data,
		input logic [`AXI_DATA_WIDTH-1:0] new_data,
		input logic [`AXI_STRB_WIDTH-1:0] strb
	);
		logic [`AXI_DATA_WIDTH-1:0] merged;
		merged = old_data;
		for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
			if (strb[i]) begin
				merged[8*i +: 8] = new_data[8*i +: 8];
			end
		end
		return merged;
	endfunction

endpackage

/* hw/soc_map_pkg.sv */
// address map targets, response codes and the address decode rule
`include "axi_macros.svh"

package soc_map_pkg;

	// where a decoded address lands
	typedef enum logic [1:0] {
		TGT_CLINT = 2'd0,
		TGT_SRAM  = 2'd1,
		TGT_NONE  = 2'd2
	} xbar_target_e;

	// bresp / rresp encodings
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// anything outside both regions is unmapped
	function automatic xbar_target_e decode_target(
		input logic [`AXI_ADDR_WIDTH-1:0] addr
	);
		if ((addr & `CLINT_MASK) == `CLINT_BASE) begin
			return TGT_CLINT;
		end else if ((addr & `SRAM_MASK) == `SRAM_BASE) begin
			return TGT_SRAM;
		end else begin
			return TGT_NONE;
		end
	endfunction

endpackage

/* hw/axi_arbiter.sv */
// round-robin arbiter passing one of two axi masters to the shared port
`timescale 1ns/1ps

module axi_arbiter import axi_pkg::*; (
	input  logic      aclk,
	input  logic      reset_i,
	input  axi_req_t  ifu_req_i,
	output axi_resp_t ifu_resp_o,
	input  axi_req_t  lsu_req_i,
	output axi_resp_t lsu_resp_o,
	output axi_req_t  bus_req_o,
	input  axi_resp_t bus_resp_i
);

	localparam logic GNT_IFU = 1'b0;
	localparam logic GNT_LSU = 1'b1;

	logic busy_q;
	logic grant_q;
	logic last_q;
	logic ifu_pending;
	logic lsu_pending;
	logic winner;
	logic txn_done;

	// a master asks for the bus with aw or ar
	assign ifu_pending = ifu_req_i.aw_valid | ifu_req_i.ar_valid;
	assign lsu_pending = lsu_req_i.aw_valid | lsu_req_i.ar_valid;

	// on a tie the master that did not win last time goes
	always_comb begin
		if (ifu_pending && lsu_pending) begin
			winner = ~last_q;
		end else if (lsu_pending) begin
			winner = GNT_LSU;
		end else begin
			winner = GNT_IFU;
		end
	end

	// single beat, so the b or r handshake closes the transaction
	assign txn_done = (bus_resp_i.b_valid & bus_req_o.b_ready) |
		(bus_resp_i.r_valid & bus_req_o.r_ready);

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			busy_q  <= 1'b0;
			grant_q <= GNT_IFU;
			last_q  <= GNT_LSU;
		end else if (!busy_q) begin
			if (ifu_pending || lsu_pending) begin
				busy_q  <= 1'b1;
				grant_q <= winner;
			end
		end else if (txn_done) begin
			busy_q <= 1'b0;
			last_q <= grant_q;
		end
	end

	// forwarding starts the cycle after the grant is latched
	always_comb begin
		bus_req_o  = '0;
		ifu_resp_o = '0;
		lsu_resp_o = '0;
		if (busy_q) begin
			if (grant_q == GNT_LSU) begin
				bus_req_o  = lsu_req_i;
				lsu_resp_o = bus_resp_i;
			end else begin
				bus_req_o  = ifu_req_i;
				ifu_resp_o = bus_resp_i;
			end
		end
	end

endmodule

/* hw/axi_xbar.sv */
// address decoder steering the shared axi port to clint, sram or a decode-error responder
`timescale 1ns/1ps
`include "axi_macros.svh"

module axi_xbar import axi_pkg::*, soc_map_pkg::*; (
	input  logic      aclk,
	input  logic      reset_i,
	input  axi_req_t  bus_req_i,
	output axi_resp_t bus_resp_o,
	output axi_req_t  clint_req_o,
	input  axi_resp_t clint_resp_i,
	output axi_req_t  sram_req_o,
	input  axi_resp_t sram_resp_i
);

	xbar_target_e aw_tgt;
	xbar_target_e ar_tgt;
	xbar_target_e wr_tgt_q;
	xbar_target_e rd_tgt_q;
	xbar_target_e wr_sel;
	xbar_target_e rd_sel;
	logic wr_pend_q;
	logic rd_pend_q;
	logic derr_b_q;
	logic derr_r_q;
	logic [`AXI_ID_WIDTH-1:0] derr_b_id_q;
	logic [`AXI_ID_WIDTH-1:0] derr_r_id_q;
	logic aw_hs;
	logic ar_hs;
	logic b_hs;
	logic r_hs;

	assign aw_tgt = decode_target(bus_req_i.aw.addr);
	assign ar_tgt = decode_target(bus_req_i.ar.addr);

	// route held from the address handshake until the response drains
	assign wr_sel = wr_pend_q ? wr_tgt_q : aw_tgt;
	assign rd_sel = rd_pend_q ? rd_tgt_q : ar_tgt;

	assign aw_hs = bus_req_i.aw_valid & bus_resp_o.aw_ready;
	assign ar_hs = bus_req_i.ar_valid & bus_resp_o.ar_ready;
	assign b_hs  = bus_resp_o.b_valid & bus_req_i.b_ready;
	assign r_hs  = bus_resp_o.r_valid & bus_req_i.r_ready;

	always_comb begin
		// payload goes everywhere, valids and readies only to the selected slave
		clint_req_o          = bus_req_i;
		clint_req_o.aw_valid = 1'b0;
		clint_req_o.w_valid  = 1'b0;
		clint_req_o.b_ready  = 1'b0;
		clint_req_o.ar_valid = 1'b0;
		clint_req_o.r_ready  = 1'b0;
		sram_req_o           = clint_req_o;
		bus_resp_o           = '0;

		case (wr_sel)
			TGT_CLINT: begin
				clint_req_o.aw_valid = bus_req_i.aw_valid;
				clint_req_o.w_valid  = bus_req_i.w_valid;
				clint_req_o.b_ready  = bus_req_i.b_ready;
				bus_resp_o.aw_ready  = clint_resp_i.aw_ready;
				bus_resp_o.w_ready   = clint_resp_i.w_ready;
				bus_resp_o.b_valid   = clint_resp_i.b_valid;
				bus_resp_o.b         = clint_resp_i.b;
			end
			TGT_SRAM: begin
				sram_req_o.aw_valid = bus_req_i.aw_valid;
				sram_req_o.w_valid  = bus_req_i.w_valid;
				sram_req_o.b_ready  = bus_req_i.b_ready;
				bus_resp_o.aw_ready = sram_resp_i.aw_ready;
				bus_resp_o.w_ready  = sram_resp_i.w_ready;
				bus_resp_o.b_valid  = sram_resp_i.b_valid;
				bus_resp_o.b        = sram_resp_i.b;
			end
			default: begin
				// unmapped write, aw and w swallowed together
				bus_resp_o.aw_ready = bus_req_i.aw_valid & bus_req_i.w_valid & ~derr_b_q;
				bus_resp_o.w_ready  = bus_req_i.aw_valid & bus_req_i.w_valid & ~derr_b_q;
				bus_resp_o.b_valid  = derr_b_q;
				bus_resp_o.b.resp   = RESP_DECERR;
				bus_resp_o.b.id     = derr_b_id_q;
			end
		endcase

		case (rd_sel)
			TGT_CLINT: begin
				clint_req_o.ar_valid = bus_req_i.ar_valid;
				clint_req_o.r_ready  = bus_req_i.r_ready;
				bus_resp_o.ar_ready  = clint_resp_i.ar_ready;
				bus_resp_o.r_valid   = clint_resp_i.r_valid;
				bus_resp_o.r         = clint_resp_i.r;
			end
			TGT_SRAM: begin
				sram_req_o.ar_valid = bus_req_i.ar_valid;
				sram_req_o.r_ready  = bus_req_i.r_ready;
				bus_resp_o.ar_ready = sram_resp_i.ar_ready;
				bus_resp_o.r_valid  = sram_resp_i.r_valid;
				bus_resp_o.r        = sram_resp_i.r;
			end
			default: begin
				bus_resp_o.ar_ready = bus_req_i.ar_valid & ~derr_r_q;
				bus_resp_o.r_valid  = derr_r_q;
				bus_resp_o.r.resp   = RESP_DECERR;
				bus_resp_o.r.data   = '0;
				bus_resp_o.r.last   = 1'b1;
				bus_resp_o.r.id     = derr_r_id_q;
			end
		endcase
	end

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			wr_pend_q <= 1'b0;
			rd_pend_q <= 1'b0;
			wr_tgt_q  <= TGT_NONE;
			rd_tgt_q  <= TGT_NONE;
			derr_b_q  <= 1'b0;
			derr_r_q  <= 1'b0;
		end else begin
			if (aw_hs) begin
				wr_pend_q <= 1'b1;
				wr_tgt_q  <= aw_tgt;
				derr_b_q  <= (aw_tgt == TGT_NONE);
			end else if (b_hs) begin
				wr_pend_q <= 1'b0;
				derr_b_q  <= 1'b0;
			end
			if (ar_hs) begin
				rd_pend_q <= 1'b1;
				rd_tgt_q  <= ar_tgt;
				derr_r_q  <= (ar_tgt == TGT_NONE);
			end else if (r_hs) begin
				rd_pend_q <= 1'b0;
				derr_r_q  <= 1'b0;
			end
		end
	end

	// id echoed on the error response
	always_ff @(posedge aclk) begin
		if (aw_hs) begin
			derr_b_id_q <= bus_req_i.aw.id;
		end
		if (ar_hs) begin
			derr_r_id_q <= bus_req_i.ar.id;
		end
	end

endmodule

/* hw/axi_clint.sv */
// clint slave with free-running mtime, writable mtimecmp and a timer interrupt
`timescale 1ns/1ps
`include "axi_macros.svh"

module axi_clint import axi_pkg::*, soc_map_pkg::*; (
	input  logic      aclk,
	input  logic      reset_i,
	input  axi_req_t  req_i,
	output axi_resp_t resp_o,
	output logic      timer_irq_o
);

	logic [`AXI_DATA_WIDTH-1:0] mtime_q;
	logic [`AXI_DATA_WIDTH-1:0] mtimecmp_q;
	logic [`AXI_ADDR_WIDTH-1:0] wr_ofs;
	logic [`AXI_ADDR_WIDTH-1:0] rd_ofs;
	logic [`AXI_DATA_WIDTH-1:0] rd_data;
	logic                       wr_take;
	logic                       rd_take;
	logic                       b_valid_q;
	logic                       r_valid_q;
	logic [`AXI_ID_WIDTH-1:0]   b_id_q;
	logic [`AXI_ID_WIDTH-1:0]   r_id_q;
	logic [`AXI_DATA_WIDTH-1:0] r_data_q;

	assign wr_ofs = req_i.aw.addr & ~`CLINT_MASK;
	assign rd_ofs = req_i.ar.addr & ~`CLINT_MASK;

	// aw and w go in together, and only with no response waiting
	assign wr_take = req_i.aw_valid & req_i.w_valid & ~b_valid_q;
	assign rd_take = req_i.ar_valid & ~r_valid_q;

	// unused offsets read as zero
	always_comb begin
		case (rd_ofs)
			`CLINT_MTIME_OFS:    rd_data = mtime_q;
			`CLINT_MTIMECMP_OFS: rd_data = mtimecmp_q;
			default:             rd_data = '0;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			mtime_q     <= '0;
			mtimecmp_q  <= '1;
			timer_irq_o <= 1'b0;
			b_valid_q   <= 1'b0;
			r_valid_q   <= 1'b0;
		end else begin
			mtime_q     <= mtime_q + 1'b1;
			timer_irq_o <= (mtime_q >= mtimecmp_q);
			if (wr_take && wr_ofs == `CLINT_MTIMECMP_OFS) begin
				mtimecmp_q <= strb_merge(mtimecmp_q, req_i.w.data, req_i.w.strb);
			end
			if (wr_take) begin
				b_valid_q <= 1'b1;
			end else if (req_i.b_ready) begin
				b_valid_q <= 1'b0;
			end
			if (rd_take) begin
				r_valid_q <= 1'b1;
			end else if (req_i.r_ready) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	// response payload, captured at acceptance
	always_ff @(posedge aclk) begin
		if (wr_take) begin
			b_id_q <= req_i.aw.id;
		end
		if (rd_take) begin
			r_id_q   <= req_i.ar.id;
			r_data_q <= rd_data;
		end
	end

	always_comb begin
		resp_o.aw_ready = wr_take;
		resp_o.w_ready  = wr_take;
		resp_o.b_valid  = b_valid_q;
		resp_o.b.resp   = RESP_OKAY;
		resp_o.b.id     = b_id_q;
		resp_o.ar_ready = rd_take;
		resp_o.r_valid  = r_valid_q;
		resp_o.r.resp   = RESP_OKAY;
		resp_o.r.data   = r_data_q;
		resp_o.r.last   = 1'b1;
		resp_o.r.id     = r_id_q;
	end

endmodule

/* hw/axi_sram.sv */
// single-beat axi slave over a 512 x 64-bit on-chip memory
`timescale 1ns/1ps
`include "axi_macros.svh"

module axi_sram import axi_pkg::*, soc_map_pkg::*; (
	input  logic      aclk,
	input  logic      reset_i,
	input  axi_req_t  req_i,
	output axi_resp_t resp_o
);

	// word index sits above the 3 byte-offset bits
	localparam int IDX_W = $clog2(`SRAM_WORDS);

	logic [`AXI_DATA_WIDTH-1:0] mem [`SRAM_WORDS];
	logic [IDX_W-1:0]           wr_idx;
	logic [IDX_W-1:0]           rd_idx;
	logic                       wr_take;
	logic                       rd_take;
	logic                       b_valid_q;
	logic                       r_valid_q;
	logic [`AXI_ID_WIDTH-1:0]   b_id_q;
	logic [`AXI_ID_WIDTH-1:0]   r_id_q;
	logic [`AXI_DATA_WIDTH-1:0] r_data_q;

	assign wr_idx = req_i.aw.addr[IDX_W+2:3];
	assign rd_idx = req_i.ar.addr[IDX_W+2:3];

	// nothing new accepted while a response is still out
	assign wr_take = req_i.aw_valid & req_i.w_valid & ~b_valid_q;
	assign rd_take = req_i.ar_valid & ~r_valid_q;

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			b_valid_q <= 1'b0;
			r_valid_q <= 1'b0;
		end else begin
			if (wr_take) begin
				b_valid_q <= 1'b1;
			end else if (req_i.b_ready) begin
				b_valid_q <= 1'b0;
			end
			if (rd_take) begin
				r_valid_q <= 1'b1;
			end else if (req_i.r_ready) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	// array and response payload
	always_ff @(posedge aclk) begin
		if (wr_take) begin
			mem[wr_idx] <= strb_merge(mem[wr_idx], req_i.w.data, req_i.w.strb);
			b_id_q      <= req_i.aw.id;
		end
		if (rd_take) begin
			r_data_q <= mem[rd_idx];
			r_id_q   <= req_i.ar.id;
		end
	end

	always_comb begin
		resp_o.aw_ready = wr_take;
		resp_o.w_ready  = wr_take;
		resp_o.b_valid  = b_valid_q;
		resp_o.b.resp   = RESP_OKAY;
		resp_o.b.id     = b_id_q;
		resp_o.ar_ready = rd_take;
		resp_o.r_valid  = r_valid_q;
		resp_o.r.resp   = RESP_OKAY;
		resp_o.r.data   = r_data_q;
		resp_o.r.last   = 1'b1;
		resp_o.r.id     = r_id_q;
	end

endmodule

/* hw/axi_subsys_top.sv */
// axi memory subsystem top joining arbiter, crossbar, clint and sram
`timescale 1ns/1ps

module axi_subsys_top import axi_pkg::*; (
	input  logic      aclk,
	input  logic      reset_i,
	input  axi_req_t  ifu_req_i,
	output axi_resp_t ifu_resp_o,
	input  axi_req_t  lsu_req_i,
	output axi_resp_t lsu_resp_o,
	output logic      timer_irq_o
);

	axi_req_t  bus_req;
	axi_resp_t bus_resp;
	axi_req_t  clint_req;
	axi_resp_t clint_resp;
	axi_req_t  sram_req;
	axi_resp_t sram_resp;

	axi_arbiter u_arbiter (
		.aclk       (aclk),
		.reset_i    (reset_i),
		.ifu_req_i  (ifu_req_i),
		.ifu_resp_o (ifu_resp_o),
		.lsu_req_i  (lsu_req_i),
		.lsu_resp_o (lsu_resp_o),
		.bus_req_o  (bus_req),
		.bus_resp_i (bus_resp)
	);

	axi_xbar u_xbar (
		.aclk         (aclk),
		.reset_i      (reset_i),
		.bus_req_i    (bus_req),
		.bus_resp_o   (bus_resp),
		.clint_req_o  (clint_req),
		.clint_resp_i (clint_resp),
		.sram_req_o   (sram_req),
		.sram_resp_i  (sram_resp)
	);

	axi_clint u_clint (
		.aclk        (aclk),
		.reset_i     (reset_i),
		.req_i       (clint_req),
		.resp_o      (clint_resp),
		.timer_irq_o (timer_irq_o)
	);

	axi_sram u_sram (
		.aclk    (aclk),
		.reset_i (reset_i),
		.req_i   (sram_req),
		.resp_o  (sram_resp)
	);

endmodule

/* verification/tb_checker.sv */
// testbench checker comparing master-port responses and the timer interrupt with golden values
`timescale 1ns/1ps
`include "axi_macros.svh"

module tb_checker import axi_pkg::*; (
	input  logic                            aclk,
	input  logic                            reset_i,
	input  axi_req_t                        ifu_req_i,
	input  axi_resp_t                       ifu_resp_i,
	input  axi_req_t                        lsu_req_i,
	input  axi_resp_t                       lsu_resp_i,
	input  logic                            timer_irq_i,
	input  logic [1:0]                      exp_valid_i,
	input  logic [1:0][1:0]                 exp_op_i,
	input  logic [1:0][`AXI_ID_WIDTH-1:0]   exp_id_i,
	input  logic [1:0][1:0]                 exp_resp_i,
	input  logic [1:0][`AXI_DATA_WIDTH-1:0] exp_data_i,
	input  logic                            irq_chk_i,
	input  logic                            irq_exp_i,
	input  int                              ifu_total_i,
	input  int                              lsu_total_i,
	input  logic                            run_done_i,
	output int                              mismatch_o,
	output int                              proto_o
);

	localparam logic [1:0] OP_WRITE = 2'd1;
	localparam logic [1:0] OP_TIME  = 2'd2;

	int mismatch_cnt = 0;
	int proto_cnt = 0;
	int seen [2] = '{0, 0};
	logic [`AXI_DATA_WIDTH-1:0] prev_mtime = '0;
	bit have_prev = 1'b0;
	bit end_done = 1'b0;

	assign mismatch_o = mismatch_cnt;
	assign proto_o    = proto_cnt;

	task automatic compare_val(input string sig, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		if (act_v !== exp_v) begin
			$display("ERR %0t %s expected %0h actual %0h", $time, sig, exp_v, act_v);
			mismatch_cnt++;
		end
	endtask

	// b and r handshakes of one master port
	task automatic check_port(input int m, input axi_req_t req, input axi_resp_t resp);
		string name;
		name = (m == 0) ? "ifu" : "lsu";
		// a valid with nothing of its kind outstanding is a stray or repeated response
		if (resp.b_valid && (!exp_valid_i[m] || exp_op_i[m] != OP_WRITE)) begin
			$display("%0t: %s received a write response with no write outstanding",
				$time, name);
			proto_cnt++;
		end else if (resp.b_valid && req.b_ready) begin
			seen[m]++;
			compare_val({name, ".b.resp"}, 64'(exp_resp_i[m]), 64'(resp.b.resp));
			compare_val({name, ".b.id"}, 64'(exp_id_i[m]), 64'(resp.b.id));
		end
		if (resp.r_valid && (!exp_valid_i[m] || exp_op_i[m] == OP_WRITE)) begin
			$display("%0t: %s received a read response with no read outstanding",
				$time, name);
			proto_cnt++;
		end else if (resp.r_valid && req.r_ready) begin
			seen[m]++;
			compare_val({name, ".r.resp"}, 64'(exp_resp_i[m]), 64'(resp.r.resp));
			compare_val({name, ".r.id"}, 64'(exp_id_i[m]), 64'(resp.r.id));
			// every transfer is a single beat
			compare_val({name, ".r.last"}, 64'(1), 64'(resp.r.last));
			if (exp_op_i[m] == OP_TIME) begin
				// mtime must move forward between reads
				if (have_prev && !(resp.r.data > prev_mtime)) begin
					$display("ERR %0t %s.r.data expected above %0h actual %0h",
						$time, name, prev_mtime, resp.r.data);
					mismatch_cnt++;
				end
				prev_mtime = resp.r.data;
				have_prev  = 1'b1;
			end else begin
				compare_val({name, ".r.data"}, exp_data_i[m], resp.r.data);
			end
		end
	endtask

	task automatic check_count(input string name, input int total, input int got);
		if (got < total) begin
			$display("%s: %0d responses never arrived", name, total - got);
			proto_cnt++;
		end
	endtask

	// sampled mid-cycle so a valid/ready pair seen here completes at the next rising edge
	always @(negedge aclk) begin
		if (!reset_i) begin
			check_port(0, ifu_req_i, ifu_resp_i);
			check_port(1, lsu_req_i, lsu_resp_i);
			if (irq_chk_i) begin
				compare_val("timer_irq_o", 64'(irq_exp_i), 64'(timer_irq_i));
			end
			if (run_done_i && !end_done) begin
				end_done = 1'b1;
				check_count("ifu", ifu_total_i, seen[0]);
				check_count("lsu", lsu_total_i, seen[1]);
			end
		end
	end

endmodule

/* verification/tb_top.sv */
// testbench top driving the ifu and lsu ports of the axi subsystem from the golden vectors
`timescale 1ns/1ps
`include "axi_macros.svh"

module tb_top import axi_pkg::*; ();

	localparam logic [1:0] OP_WRITE = 2'd1;
	localparam logic [1:0] OP_IRQ   = 2'd3;
	localparam int IRQ_BOUND = 16;

	typedef struct packed {
		logic [1:0]                 op;
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [`AXI_DATA_WIDTH-1:0] wdata;
		logic [`AXI_STRB_WIDTH-1:0] strb;
		logic [1:0]                 resp;
		logic [`AXI_DATA_WIDTH-1:0] rdata;
	} vec_t;

	logic      aclk;
	logic      reset_i;
	axi_req_t  ifu_req;
	axi_resp_t ifu_resp;
	axi_req_t  lsu_req;
	axi_resp_t lsu_resp;
	logic      timer_irq;
	logic [1:0]                      exp_valid;
	logic [1:0][1:0]                 exp_op;
	logic [1:0][`AXI_ID_WIDTH-1:0]   exp_id;
	logic [1:0][1:0]                 exp_resp;
	logic [1:0][`AXI_DATA_WIDTH-1:0] exp_data;
	logic irq_chk;
	logic irq_exp;
	logic run_done;
	int   ifu_total;
	int   lsu_total;
	int   mismatch;
	int   proto;
	int   cycles = 0;
	int   limit = 0;
	vec_t ifu_q[$];
	vec_t lsu_q[$];

	axi_subsys_top uut (
		.aclk        (aclk),
		.reset_i     (reset_i),
		.ifu_req_i   (ifu_req),
		.ifu_resp_o  (ifu_resp),
		.lsu_req_i   (lsu_req),
		.lsu_resp_o  (lsu_resp),
		.timer_irq_o (timer_irq)
	);

	tb_checker u_checker (
		.aclk        (aclk),
		.reset_i     (reset_i),
		.ifu_req_i   (ifu_req),
		.ifu_resp_i  (ifu_resp),
		.lsu_req_i   (lsu_req),
		.lsu_resp_i  (lsu_resp),
		.timer_irq_i (timer_irq),
		.exp_valid_i (exp_valid),
		.exp_op_i    (exp_op),
		.exp_id_i    (exp_id),
		.exp_resp_i  (exp_resp),
		.exp_data_i  (exp_data),
		.irq_chk_i   (irq_chk),
		.irq_exp_i   (irq_exp),
		.ifu_total_i (ifu_total),
		.lsu_total_i (lsu_total),
		.run_done_i  (run_done),
		.mismatch_o  (mismatch),
		.proto_o     (proto)
	);

	initial begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	always @(posedge aclk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles with transactions still outstanding", cycles);
			run_done = 1'b1;
			@(negedge aclk);
			#1;
			$display("closing: %0d value errors, %0d protocol errors", mismatch, proto);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic load_golden(output bit ok);
		int fd;
		string line;
		logic [63:0] f_m, f_op, f_id, f_addr, f_wdata, f_strb, f_resp, f_rdata;
		vec_t v;
		ok = 1'b0;
		fd = $fopen("verification/golden_vectors.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_m, f_op, f_id, f_addr,
						f_wdata, f_strb, f_resp, f_rdata) != 8) begin
						$display("malformed golden line: %s", line);
						ok = 1'b0;
					end else begin
						v.op    = f_op[1:0];
						v.id    = f_id[`AXI_ID_WIDTH-1:0];
						v.addr  = f_addr[`AXI_ADDR_WIDTH-1:0];
						v.wdata = f_wdata;
						v.strb  = f_strb[`AXI_STRB_WIDTH-1:0];
						v.resp  = f_resp[1:0];
						v.rdata = f_rdata;
						if (f_m[0]) begin
							lsu_q.push_back(v);
							lsu_total += (v.op != OP_IRQ) ? 1 : 0;
						end else begin
							ifu_q.push_back(v);
							ifu_total += (v.op != OP_IRQ) ? 1 : 0;
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// background pattern built from the full byte address of each word
	task automatic fill_sram();
		logic [`AXI_ADDR_WIDTH-1:0] a;
		for (int i = 0; i < `SRAM_WORDS; i++) begin
			a = `SRAM_BASE + 32'(i * 8);
			uut.u_sram.mem[i] = {~a, a};
		end
	endtask

	task automatic put_req(input int m, input axi_req_t r);
		if (m == 0)
			ifu_req = r;
		else
			lsu_req = r;
	endtask

	function automatic bit addr_taken(input int m);
		axi_req_t  r;
		axi_resp_t s;
		r = (m == 0) ? ifu_req : lsu_req;
		s = (m == 0) ? ifu_resp : lsu_resp;
		return (r.aw_valid && s.aw_ready && r.w_valid && s.w_ready) ||
			(r.ar_valid && s.ar_ready);
	endfunction

	function automatic bit resp_taken(input int m);
		axi_req_t  r;
		axi_resp_t s;
		r = (m == 0) ? ifu_req : lsu_req;
		s = (m == 0) ? ifu_resp : lsu_resp;
		return (s.b_valid && r.b_ready) || (s.r_valid && r.r_ready);
	endfunction

	// one single-beat transaction entered and left 1 ns after a rising edge
	task automatic issue_txn(input int m, input vec_t v);
		axi_req_t r;
		int stall;
		bit got;
		r = '0;
		exp_op[m]    = v.op;
		exp_id[m]    = v.id;
		exp_resp[m]  = v.resp;
		exp_data[m]  = v.rdata;
		exp_valid[m] = 1'b1;
		if (v.op == OP_WRITE) begin
			r.aw_valid = 1'b1;
			r.aw.addr  = v.addr;
			r.aw.id    = v.id;
			r.aw.size  = 3'd3;
			r.aw.burst = 2'b01;
			r.w_valid  = 1'b1;
			r.w.data   = v.wdata;
			r.w.strb   = v.strb;
			r.w.last   = 1'b1;
		end else begin
			r.ar_valid = 1'b1;
			r.ar.addr  = v.addr;
			r.ar.id    = v.id;
			r.ar.size  = 3'd3;
			r.ar.burst = 2'b01;
		end
		put_req(m, r);
		got = 1'b0;
		while (!got) begin
			@(negedge aclk);
			got = addr_taken(m);
		end
		@(posedge aclk);
		#1;
		r.aw_valid = 1'b0;
		r.w_valid  = 1'b0;
		r.ar_valid = 1'b0;
		put_req(m, r);
		// response back-pressure
		stall = $urandom % 4;
		repeat (stall) begin
			@(posedge aclk);
			#1;
		end
		r.b_ready = (v.op == OP_WRITE);
		r.r_ready = (v.op != OP_WRITE);
		put_req(m, r);
		got = 1'b0;
		while (!got) begin
			@(negedge aclk);
			got = resp_taken(m);
		end
		@(posedge aclk);
		#1;
		r.b_ready = 1'b0;
		r.r_ready = 1'b0;
		put_req(m, r);
		exp_valid[m] = 1'b0;
	endtask

	// level sits in the wdata column
	task automatic wait_irq(input vec_t v);
		int n;
		n = 0;
		while (timer_irq !== v.wdata[0] && n < IRQ_BOUND) begin
			@(negedge aclk);
			n++;
		end
		@(posedge aclk);
		#1;
		irq_exp = v.wdata[0];
		irq_chk = 1'b1;
		@(posedge aclk);
		#1;
		irq_chk = 1'b0;
	endtask

	task automatic drive_master(input int m);
		vec_t v;
		int n;
		n = (m == 0) ? ifu_q.size() : lsu_q.size();
		for (int i = 0; i < n; i++) begin
			v = (m == 0) ? ifu_q[i] : lsu_q[i];
			if (v.op == OP_IRQ)
				wait_irq(v);
			else
				issue_txn(m, v);
		end
	endtask

	initial begin
		bit ok;
		void'($urandom(12903));
		reset_i   = 1'b1;
		ifu_req   = '0;
		lsu_req   = '0;
		exp_valid = '0;
		exp_op    = '0;
		exp_id    = '0;
		exp_resp  = '0;
		exp_data  = '0;
		irq_chk   = 1'b0;
		irq_exp   = 1'b0;
		run_done  = 1'b0;
		ifu_total = 0;
		lsu_total = 0;
		load_golden(ok);
		if (!ok) begin
			$display("golden vector file could not be opened or holds a bad line");
			$display("Simulation failed");
			$finish;
		end else begin
			limit = 40 * (ifu_q.size() + lsu_q.size()) + 200;
			fill_sram();
			repeat (5) @(posedge aclk);
			#1;
			reset_i = 1'b0;
			fork
				drive_master(0);
				drive_master(1);
			join
			repeat (2) @(posedge aclk);
			#1;
			run_done = 1'b1;
			repeat (2) @(posedge aclk);
			$display("closing: %0d value errors, %0d protocol errors", mismatch, proto);
			if (mismatch == 0 && proto == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

/* verification/golden_vectors.txt */
# master(0 ifu, 1 lsu) op(0 read, 1 write, 2 mtime read, 3 irq wait) id addr wdata strb resp rdata
# all hex; for op 3 the wdata column holds the timer_irq_o level to wait for
0 0 1 80000100 0 0 0 7ffffeff80000100
0 0 2 80000108 0 0 0 7ffffef780000108
0 0 1 80000110 0 0 0 7ffffeef80000110
0 0 2 80000118 0 0 0 7ffffee780000118
0 0 3 10000000 0 0 3 0
0 0 1 80000ff8 0 0 0 7ffff00780000ff8
0 0 2 80000200 0 0 0 7ffffdff80000200
0 0 1 80000800 0 0 0 7ffff7ff80000800
1 1 4 80000010 1122334455667788 ff 0 0
1 0 4 80000010 0 0 0 1122334455667788
1 1 5 80000010 aaaaaaaaaaaaaaaa 0f 0 0
1 0 5 80000010 0 0 0 11223344aaaaaaaa
1 1 6 80000010 bbbbbbbbbbbbbbbb 81 0 0
1 0 6 80000010 0 0 0 bb223344aaaaaabb
1 1 7 80000018 0123456789abcdef ff 0 0
1 1 8 80000018 ffffffffffffffff 3c 0 0
1 0 8 80000018 0 0 0 0123ffffffffcdef
1 0 9 80000010 0 0 0 bb223344aaaaaabb
1 0 a 80000ff0 0 0 0 7ffff00f80000ff0
1 1 5 40000000 1234 ff 3 0
1 0 6 40000008 0 0 3 0
1 0 b 80001000 0 0 3 0
1 1 1 02004000 10 ff 0 0
1 0 1 02004000 0 0 0 10
1 3 0 0 1 0 0 0
1 2 2 0200bff8 0 0 0 0
1 2 3 0200bff8 0 0 0 0
1 0 4 02000100 0 0 0 0
1 1 1 02004000 ffffffffffffffff ff 0 0
1 0 2 02004000 0 0 0 ffffffffffffffff
1 3 0 0 0 0 0 0

/* tb.f */
+incdir+hw
hw/axi_pkg.sv
hw/soc_map_pkg.sv
hw/axi_arbiter.sv
hw/axi_xbar.sv
hw/axi_clint.sv
hw/axi_sram.sv
hw/axi_subsys_top.sv
verification/tb_checker.sv
verification/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it into sim.log, and judge the run from the log

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f \
	&& ./obj_dir/Vtb_top > sim.log 2>&1

grep -q "Simulation passed" sim.log \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail, see sim.log"; exit 1; }
